// File: filelist.f
src/adc_pkg.sv
src/adc_apb_regs.sv
src/adc_serial_port.sv
src/sample_decimator.sv
src/capture_ctrl.sv
src/adc_capture_top.sv
bench/adc_capture_properties.sv
bench/tb_adc_capture.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_capture
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= TB FAILED
PASS_MSG  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_adc_capture.sv
module tb_adc_capture;

	localparam int SCLK_HALF      = 2;
	localparam int TIMEOUT_CYCLES = 4000; // sequence needs well under 1000 cycles

	logic               adc_clkinp;
	logic               ADC_RESET;
	adc_pkg::apb_req_t  apb;
	logic [31:0]        prdata;
	logic               pready;
	adc_pkg::frame_t    sample_frame = '0;
	logic               tx_trig;
	logic               tx_trig_ack;
	adc_pkg::ram_wr_t   ram_wr;
	logic               irq;
	logic               var_atten;
	logic               adc_rst;
	logic               adc_pdn;
	logic               adc_sen;
	logic               adc_sclk;
	logic               adc_sdata;

	integer             seed = 32'hce69_3bbb;
	int                 errors = 0;
	int                 cycles = 0;
	int                 check_mode = 0; // 0 off, 1 delayed frame, 2 group sum
	int                 group_len = 1;
	logic               hold_frame = 1'b0;
	adc_pkg::frame_t    const_frame = '0;
	adc_pkg::frame_t    frame_d1 = '0;
	adc_pkg::frame_t    frame_d2 = '0;
	int                 wr_count = 0;
	int                 ser_count = 0;
	logic [23:0]        ser_bits = '0;
	logic               sclk_q = 1'b0;
	logic               sen_q = 1'b1;
	logic               ack_q = 1'b0;
	logic [23:0]        cmd;

	adc_capture_top #(
		.SCLK_HALF (SCLK_HALF)
	) u_dut (
		.adc_clkinp   (adc_clkinp),
		.ADC_RESET    (ADC_RESET),
		.apb          (apb),
		.prdata       (prdata),
		.pready       (pready),
		.sample_frame (sample_frame),
		.tx_trig      (tx_trig),
		.tx_trig_ack  (tx_trig_ack),
		.ram_wr       (ram_wr),
		.irq          (irq),
		.var_atten    (var_atten),
		.adc_rst      (adc_rst),
		.adc_pdn      (adc_pdn),
		.adc_sen      (adc_sen),
		.adc_sclk     (adc_sclk),
		.adc_sdata    (adc_sdata)
	);

	initial
	begin
		adc_clkinp = 1'b0;
		forever #10 adc_clkinp = ~adc_clkinp;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	function automatic adc_pkg::frame_t random_frame();
		adc_pkg::frame_t f;
		logic [31:0]     r;
		for (int n = 0; n < 8; n++)
		begin
			r = $random(seed);
			f.ch[n] = r[11:0];
		end
		return f;
	endfunction

	function automatic adc_pkg::ram_word_t zero_extend_frame(input adc_pkg::frame_t f);
		adc_pkg::ram_word_t w;
		for (int n = 0; n < 8; n++)
			w[n] = {4'd0, f.ch[n]};
		return w;
	endfunction

	function automatic adc_pkg::ram_word_t expected_sum(input adc_pkg::frame_t f, input int len);
		adc_pkg::ram_word_t w;
		for (int n = 0; n < 8; n++)
			w[n] = 16'(len) * {4'd0, f.ch[n]}; // same frame summed len times
		return w;
	endfunction

	function automatic logic [31:0] settings_word(input logic atten, input int decim,
		input logic sum, input logic irq_t);
		adc_pkg::settings_t s;
		s.var_atten = atten;
		s.decim     = adc_pkg::decim_t'(decim);
		s.sum_mode  = sum;
		s.irq_test  = irq_t;
		return 32'(s);
	endfunction

	task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
		@(negedge adc_clkinp);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge adc_clkinp);
		apb.penable = 1'b1;
		@(negedge adc_clkinp);
		assert (pready) else report_error("pready low in the write access cycle");
		apb = '0;
	endtask

	task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
		@(negedge adc_clkinp);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(negedge adc_clkinp);
		apb.penable = 1'b1;
		data = prdata; // address held since setup
		@(negedge adc_clkinp);
		assert (pready) else report_error("pready low in the read access cycle");
		apb = '0;
	endtask

	task automatic run_op(input adc_pkg::adc_op_e op);
		apb_write(adc_pkg::REG_OP, 32'(op));
		@(negedge adc_clkinp); // strobe reaches the pins
	endtask

	task automatic fire_trigger();
		@(negedge adc_clkinp);
		tx_trig = 1'b1;
		@(negedge adc_clkinp);
		tx_trig = 1'b0;
		assert (tx_trig_ack) else report_error("tx_trig_ack not high one clock after trigger");
		@(negedge adc_clkinp); // monitor restarts its write count
	endtask

	task automatic run_capture(input int decim, input logic sum, input int len);
		logic [31:0] rd;
		apb_write(adc_pkg::REG_SETTINGS, settings_word(1'b0, decim, sum, 1'b0));
		apb_write(adc_pkg::REG_REC_LEN, 32'(len));
		group_len  = decim + 1;
		check_mode = sum ? 2 : 1;
		apb_write(adc_pkg::REG_ARM, 32'd1);
		fire_trigger();
		while (wr_count < len)
			@(negedge adc_clkinp);
		assert (!tx_trig_ack && irq)
		else report_error($sformatf("after last write ack=%b irq=%b", tx_trig_ack, irq));
		apb_read(adc_pkg::REG_STATUS, rd);
		assert (rd[0]) else report_error("STATUS done bit not set after the last write");
		repeat (20) @(negedge adc_clkinp);
		assert (wr_count == len)
		else report_error($sformatf("%0d writes seen, %0d expected", wr_count, len));
		check_mode = 0;
		apb_write(adc_pkg::REG_ARM, 32'd0);
		assert (!irq) else report_error("irq still high after disarm with irq_test low");
	endtask

	always @(negedge adc_clkinp)
	begin
		if (hold_frame)
			sample_frame = const_frame;
		else
			sample_frame = random_frame();
	end

	// everything here is sampled at the rising edge
	always @(posedge adc_clkinp)
	begin
		if (!adc_sen && sen_q)
		begin
			ser_count = 0;
			ser_bits  = '0;
		end
		if (adc_sclk && !sclk_q && !adc_sen)
		begin
			ser_bits  = {ser_bits[22:0], adc_sdata};
			ser_count = ser_count + 1;
		end
		if (tx_trig_ack && !ack_q)
			wr_count = 0;
		if (ram_wr.en)
		begin
			assert (ram_wr.addr == adc_pkg::waddr_t'(wr_count))
			else report_error($sformatf("write address %0d, expected %0d", ram_wr.addr, wr_count));
			if (check_mode == 1)
				assert (ram_wr.data == zero_extend_frame(frame_d2))
				else report_error($sformatf("write data %h, expected %h", ram_wr.data,
					zero_extend_frame(frame_d2)));
			if (check_mode == 2)
				assert (ram_wr.data == expected_sum(const_frame, group_len))
				else report_error($sformatf("sum data %h, expected %h", ram_wr.data,
					expected_sum(const_frame, group_len)));
			wr_count = wr_count + 1;
		end
		sclk_q   = adc_sclk;
		sen_q    = adc_sen;
		ack_q    = tx_trig_ack;
		frame_d2 = frame_d1;
		frame_d1 = sample_frame;
	end

	always @(posedge adc_clkinp)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	initial
	begin
		ADC_RESET   = 1'b1;
		apb         = '0;
		tx_trig     = 1'b0;
		cmd         = 24'($random(seed));
		const_frame = random_frame();
		repeat (16) @(negedge adc_clkinp);
		ADC_RESET = 1'b0;

		run_op(adc_pkg::op_hw_reset);
		assert (adc_rst) else report_error("adc_rst low after op_hw_reset");
		run_op(adc_pkg::op_pdn_on);
		assert (adc_pdn) else report_error("adc_pdn low after op_pdn_on");
		run_op(adc_pkg::op_idle);
		run_op(adc_pkg::op_pdn_off);
		assert (!adc_rst && !adc_pdn) else report_error("adc_rst or adc_pdn did not clear");

		apb_write(adc_pkg::REG_SERIAL_CMD, 32'(cmd));
		run_op(adc_pkg::op_load_cmd);
		run_op(adc_pkg::op_issue_cmd);
		while (!adc_sen)
			@(negedge adc_clkinp);
		assert (ser_count == 24)
		else report_error($sformatf("%0d sclk rising edges in enable window", ser_count));
		assert (ser_bits == cmd)
		else report_error($sformatf("serial bits %h, expected %h", ser_bits, cmd));

		run_capture(0, 1'b0, 8);
		hold_frame = 1'b1; // group sum needs a steady frame
		run_capture(3, 1'b1, 5);
		hold_frame = 1'b0;

		apb_write(adc_pkg::REG_ARM, 32'd1);
		apb_write(adc_pkg::REG_SETTINGS, settings_word(1'b1, 0, 1'b0, 1'b0));
		assert (!var_atten) else report_error("settings write while armed changed var_atten");
		apb_write(adc_pkg::REG_ARM, 32'd0);
		apb_write(adc_pkg::REG_SETTINGS, settings_word(1'b1, 0, 1'b0, 1'b1));
		assert (var_atten) else report_error("settings write while disarmed lost var_atten");
		assert (irq) else report_error("irq low with irq_test high while disarmed");
		apb_write(adc_pkg::REG_SETTINGS, settings_word(1'b1, 0, 1'b0, 1'b0));
		assert (!irq) else report_error("irq high with irq_test low while disarmed");

		$display("summary: %0d check errors, %0d assertion failures", errors,
			u_dut.u_props.fail_cnt);
		if (errors == 0 && u_dut.u_props.fail_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: bench/adc_capture_properties.sv
module adc_capture_properties (
	input logic              adc_clkinp,
	input logic              ADC_RESET,
	input logic              tx_trig,
	input logic              tx_trig_ack,
	input adc_pkg::ram_wr_t  ram_wr,
	input logic              irq,
	input logic              adc_sen,
	input logic              adc_sclk,
	input logic              adc_sdata
);

	int fail_cnt = 0;

	reset_levels: assert property (@(posedge adc_clkinp)
		ADC_RESET |=> (adc_sen && !adc_sclk && !tx_trig_ack && !ram_wr.en && !irq))
	else
	begin
		fail_cnt++;
		$error("outputs not at reset levels after ADC_RESET");
	end

	sclk_idle_low: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		adc_sen |-> !adc_sclk)
	else
	begin
		fail_cnt++;
		$error("adc_sclk high outside the enable window");
	end

	// data only moves while sclk is low
	sdata_steady: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		adc_sclk |-> $stable(adc_sdata))
	else
	begin
		fail_cnt++;
		$error("adc_sdata changed while adc_sclk high");
	end

	ack_after_trig: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		$rose(tx_trig_ack) |-> $past(tx_trig))
	else
	begin
		fail_cnt++;
		$error("tx_trig_ack rose without a trigger");
	end

	write_in_run: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		ram_wr.en |-> (tx_trig_ack && !irq))
	else
	begin
		fail_cnt++;
		$error("RAM write outside a running capture");
	end

	addr_step: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		(ram_wr.en && $past(ram_wr.en)) |-> (ram_wr.addr == $past(ram_wr.addr) + 1'b1))
	else
	begin
		fail_cnt++;
		$error("back to back writes with non-consecutive addresses");
	end

endmodule

bind adc_capture_top adc_capture_properties u_props (
	.adc_clkinp  (adc_clkinp),
	.ADC_RESET   (ADC_RESET),
	.tx_trig     (tx_trig),
	.tx_trig_ack (tx_trig_ack),
	.ram_wr      (ram_wr),
	.irq         (irq),
	.adc_sen     (adc_sen),
	.adc_sclk    (adc_sclk),
	.adc_sdata   (adc_sdata)
);

// File: src/adc_capture_top.sv
module adc_capture_top #(
	parameter int SCLK_HALF = 2
) (
	input  logic               adc_clkinp,
	input  logic               ADC_RESET,
	input  adc_pkg::apb_req_t  apb,
	output logic [31:0]        prdata,
	output logic               pready,
	input  adc_pkg::frame_t    sample_frame,
	input  logic               tx_trig,
	output logic               tx_trig_ack,
	output adc_pkg::ram_wr_t   ram_wr,
	output logic               irq,
	output logic               var_atten,
	output logic               adc_rst,
	output logic               adc_pdn,
	output logic               adc_sen,
	output logic               adc_sclk,
	output logic               adc_sdata
);

	adc_pkg::adc_op_e             op;
	logic                         op_strobe;
	logic [adc_pkg::SER_BITS-1:0] ser_cmd;
	adc_pkg::settings_t           settings;
	logic                         arm;
	adc_pkg::waddr_t              rec_len;
	logic                         serial_busy;
	logic                         done;
	logic                         run;
	logic                         word_valid;
	adc_pkg::ram_word_t           word;

	assign var_atten = settings.var_atten;

	adc_apb_regs u_regs (
		.adc_clkinp  (adc_clkinp),
		.ADC_RESET   (ADC_RESET),
		.apb         (apb),
		.prdata      (prdata),
		.pready      (pready),
		.op          (op),
		.op_strobe   (op_strobe),
		.ser_cmd     (ser_cmd),
		.settings    (settings),
		.arm         (arm),
		.rec_len     (rec_len),
		.serial_busy (serial_busy),
		.done        (done)
	);

	adc_serial_port #(
		.SCLK_HALF (SCLK_HALF)
	) u_serial (
		.adc_clkinp  (adc_clkinp),
		.ADC_RESET   (ADC_RESET),
		.op          (op),
		.op_strobe   (op_strobe),
		.ser_cmd     (ser_cmd),
		.adc_rst     (adc_rst),
		.adc_pdn     (adc_pdn),
		.adc_sen     (adc_sen),
		.adc_sclk    (adc_sclk),
		.adc_sdata   (adc_sdata),
		.serial_busy (serial_busy)
	);

	sample_decimator u_decim (
		.adc_clkinp   (adc_clkinp),
		.ADC_RESET    (ADC_RESET),
		.run          (run),
		.settings     (settings),
		.sample_frame (sample_frame),
		.word_valid   (word_valid),
		.word         (word)
	);

	capture_ctrl u_capture (
		.adc_clkinp  (adc_clkinp),
		.ADC_RESET   (ADC_RESET),
		.arm         (arm),
		.rec_len     (rec_len),
		.tx_trig     (tx_trig),
		.word_valid  (word_valid),
		.word        (word),
		.irq_test    (settings.irq_test),
		.run         (run),
		.tx_trig_ack (tx_trig_ack),
		.ram_wr      (ram_wr),
		.done        (done),
		.irq         (irq)
	);

endmodule

// File: src/capture_ctrl.sv
module capture_ctrl (
	input  logic                adc_clkinp,
	input  logic                ADC_RESET,
	input  logic                arm,
	input  adc_pkg::waddr_t     rec_len,
	input  logic                tx_trig,
	input  logic                word_valid,
	input  adc_pkg::ram_word_t  word,
	input  logic                irq_test,
	output logic                run,
	output logic                tx_trig_ack,
	output adc_pkg::ram_wr_t    ram_wr,
	output logic                done,
	output logic                irq
);

	typedef enum logic [1:0] {
		st_idle,
		st_capture,
		st_done
	} cap_state_e;

	cap_state_e         state;
	adc_pkg::waddr_t    waddr;
	logic               wr_en;
	adc_pkg::waddr_t    wr_addr;
	adc_pkg::ram_word_t wr_data;
	logic               all_issued;

	assign all_issued  = (waddr == rec_len);
	assign run         = (state == st_capture);
	assign tx_trig_ack = (state == st_capture);
	assign done        = (state == st_done);
	assign irq         = arm ? done : irq_test;
	assign ram_wr      = '{en: wr_en, addr: wr_addr, data: wr_data};

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
		begin
			state <= st_idle;
			waddr <= '0;
			wr_en <= 1'b0;
		end
		else if (!arm)
		begin
			state <= st_idle;
			waddr <= '0;
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= 1'b0;
			case (state)
				st_idle:
				begin
					waddr <= '0;
					if (tx_trig)
						state <= (rec_len == '0) ? st_done : st_capture;
				end
				st_capture:
				begin
					if (all_issued)
						state <= st_done; // last write has gone out
					else if (word_valid)
					begin
						wr_en <= 1'b1;
						waddr <= waddr + 1'b1;
					end
				end
				st_done:;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (word_valid)
		begin
			wr_addr <= waddr;
			wr_data <= word;
		end
	end

endmodule

// File: src/sample_decimator.sv
module sample_decimator (
	input  logic                adc_clkinp,
	input  logic                ADC_RESET,
	input  logic                run,
	input  adc_pkg::settings_t  settings,
	input  adc_pkg::frame_t     sample_frame,
	output logic                word_valid,
	output adc_pkg::ram_word_t  word
);

	adc_pkg::decim_t    frame_cnt;
	adc_pkg::ram_word_t frame_ext;
	adc_pkg::ram_word_t acc;
	adc_pkg::ram_word_t next_acc;
	logic               group_end;

	assign group_end = (frame_cnt == settings.decim);

	always_comb
	begin
		for (int n = 0; n < 8; n++)
		begin
			frame_ext[n] = adc_pkg::lane_t'(sample_frame.ch[n]); // zero extend
			if (frame_cnt == '0)
				next_acc[n] = frame_ext[n];
			else if (settings.sum_mode)
				next_acc[n] = acc[n] + frame_ext[n];
			else
				next_acc[n] = acc[n]; // keep first frame
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
		begin
			frame_cnt  <= '0;
			word_valid <= 1'b0;
		end
		else if (!run)
		begin
			frame_cnt  <= '0; // next run starts a fresh group
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= group_end;
			if (group_end)
				frame_cnt <= '0;
			else
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (run)
		begin
			acc <= next_acc;
			if (group_end)
				word <= next_acc;
		end
	end

endmodule

// File: src/adc_serial_port.sv
module adc_serial_port #(
	parameter int SCLK_HALF = 2
) (
	input  logic                          adc_clkinp,
	input  logic                          ADC_RESET,
	input  adc_pkg::adc_op_e              op,
	input  logic                          op_strobe,
	input  logic [adc_pkg::SER_BITS-1:0]  ser_cmd,
	output logic                          adc_rst,
	output logic                          adc_pdn,
	output logic                          adc_sen,
	output logic                          adc_sclk,
	output logic                          adc_sdata,
	output logic                          serial_busy
);

	localparam int HALF_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
	localparam int BIT_W  = $clog2(adc_pkg::SER_BITS);
	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SCLK_HALF - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(adc_pkg::SER_BITS - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_shift_low,
		st_shift_high
	} ser_state_e;

	ser_state_e                   state;
	logic [adc_pkg::SER_BITS-1:0] shift_buf;
	logic [HALF_W-1:0]            half_cnt;
	logic [BIT_W-1:0]             bit_cnt;

	assign serial_busy = (state != st_idle) | (op_strobe & (op == adc_pkg::op_issue_cmd));

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
		begin
			state     <= st_idle;
			shift_buf <= '0;
			half_cnt  <= '0;
			bit_cnt   <= '0;
			adc_rst   <= 1'b0;
			adc_pdn   <= 1'b0;
			adc_sen   <= 1'b1;
			adc_sclk  <= 1'b0;
			adc_sdata <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (op_strobe)
					begin
						case (op)
							adc_pkg::op_idle:     adc_rst <= 1'b0;
							adc_pkg::op_hw_reset: adc_rst <= 1'b1;
							adc_pkg::op_pdn_on:   adc_pdn <= 1'b1;
							adc_pkg::op_pdn_off:  adc_pdn <= 1'b0;
							adc_pkg::op_load_cmd: shift_buf <= ser_cmd;
							adc_pkg::op_issue_cmd:
							begin
								state     <= st_shift_low;
								adc_sen   <= 1'b0;
								adc_sdata <= shift_buf[adc_pkg::SER_BITS-1]; // msb first
								shift_buf <= {shift_buf[adc_pkg::SER_BITS-2:0], 1'b0};
								half_cnt  <= '0;
								bit_cnt   <= '0;
							end
							default:;
						endcase
					end
				end
				st_shift_low:
				begin
					if (half_cnt == HALF_LAST)
					begin
						half_cnt <= '0;
						adc_sclk <= 1'b1;
						state    <= st_shift_high;
					end
					else
						half_cnt <= half_cnt + 1'b1;
				end
				st_shift_high:
				begin
					if (half_cnt == HALF_LAST)
					begin
						half_cnt <= '0;
						adc_sclk <= 1'b0;
						if (bit_cnt == BIT_LAST)
						begin
							state     <= st_idle;
							adc_sen   <= 1'b1;
							adc_sdata <= 1'b0;
						end
						else
						begin
							bit_cnt   <= bit_cnt + 1'b1;
							adc_sdata <= shift_buf[adc_pkg::SER_BITS-1];
							shift_buf <= {shift_buf[adc_pkg::SER_BITS-2:0], 1'b0};
							state     <= st_shift_low;
						end
					end
					else
						half_cnt <= half_cnt + 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: src/adc_apb_regs.sv
module adc_apb_regs (
	input  logic                          adc_clkinp,
	input  logic                          ADC_RESET,
	input  adc_pkg::apb_req_t             apb,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output adc_pkg::adc_op_e              op,
	output logic                          op_strobe,
	output logic [adc_pkg::SER_BITS-1:0]  ser_cmd,
	output adc_pkg::settings_t            settings,
	output logic                          arm,
	output adc_pkg::waddr_t               rec_len,
	input  logic                          serial_busy,
	input  logic                          done
);

	logic wr_access;

	assign wr_access = apb.psel & apb.penable & apb.pwrite;
	assign pready = 1'b1; // no wait states

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
		begin
			op        <= adc_pkg::op_idle;
			op_strobe <= 1'b0;
			ser_cmd   <= '0;
			settings  <= '0;
			arm       <= 1'b0;
			rec_len   <= '0;
		end
		else
		begin
			op_strobe <= 1'b0;
			if (wr_access)
			begin
				case (apb.paddr)
					adc_pkg::REG_OP:
					begin
						op        <= adc_pkg::adc_op_e'(apb.pwdata[2:0]);
						op_strobe <= 1'b1;
					end
					adc_pkg::REG_SETTINGS:
					begin
						if (!arm) // locked while armed
							settings <= apb.pwdata[$bits(adc_pkg::settings_t)-1:0];
					end
					adc_pkg::REG_SERIAL_CMD: ser_cmd <= apb.pwdata[adc_pkg::SER_BITS-1:0];
					adc_pkg::REG_REC_LEN:    rec_len <= apb.pwdata[$bits(adc_pkg::waddr_t)-1:0];
					adc_pkg::REG_ARM:        arm <= apb.pwdata[0];
					default:;
				endcase
			end
		end
	end

	always_comb
	begin
		prdata = '0;
		case (apb.paddr)
			adc_pkg::REG_OP:         prdata = 32'(op);
			adc_pkg::REG_SETTINGS:   prdata = 32'(settings);
			adc_pkg::REG_SERIAL_CMD: prdata = 32'(ser_cmd);
			adc_pkg::REG_REC_LEN:    prdata = 32'(rec_len);
			adc_pkg::REG_ARM:        prdata = 32'(arm);
			adc_pkg::REG_STATUS:     prdata = {30'd0, serial_busy, done};
			default:                 prdata = '0;
		endcase
	end

endmodule

// File: src/adc_pkg.sv
package adc_pkg;

	localparam int SER_BITS = 24;

	typedef logic [11:0] sample_t;
	typedef logic [15:0] lane_t;
	typedef logic [14:0] waddr_t;
	typedef logic [3:0]  decim_t; // group length is decim+1

	typedef struct packed {
		sample_t [7:0] ch; // ch[n] is channel n
	} frame_t;

	typedef lane_t [7:0] ram_word_t; // lane n holds channel n

	typedef enum logic [2:0] {
		op_idle      = 3'd0,
		op_hw_reset  = 3'd1,
		op_load_cmd  = 3'd2,
		op_issue_cmd = 3'd3,
		op_pdn_on    = 3'd4,
		op_pdn_off   = 3'd5
	} adc_op_e;

	typedef struct packed {
		logic   var_atten;
		decim_t decim;
		logic   sum_mode; // 1 sums each group per lane
		logic   irq_test;
	} settings_t;

	typedef struct packed {
		logic      en;
		waddr_t    addr;
		ram_word_t data;
	} ram_wr_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [4:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	localparam logic [4:0] REG_OP         = 5'h00;
	localparam logic [4:0] REG_SETTINGS   = 5'h04;
	localparam logic [4:0] REG_SERIAL_CMD = 5'h08;
	localparam logic [4:0] REG_REC_LEN    = 5'h0C;
	localparam logic [4:0] REG_ARM        = 5'h10;
	localparam logic [4:0] REG_STATUS     = 5'h14;

endpackage
